//--- Bender.yml
package:
  name: dsi_packet_assembler

sources:
  - dsi_pkg.sv
  - header_ecc.sv
  - payload_crc.sv
  - hdr_queue.sv
  - frame_sequencer.sv
  - packet_mux.sv
  - lane_distributor.sv
  - dsi_packet_assembler.sv
  - target: test
    files:
      - dsi_packet_assembler_assert.sv
      - tb_dsi_packet_assembler.sv

//--- dsi_packet_assembler.sv
`timescale 1ns/1ps

module dsi_packet_assembler (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 streaming_enable,
    input  logic [2:0]           lane_count,
    input  dsi_pkg::timing_cfg_t timing_cfg,
    input  logic [31:0]          pix_data,
    input  logic                 pix_empty,
    output logic                 pix_read,
    output dsi_pkg::lane_word_t  lane_data,
    output dsi_pkg::lane_mask_t  lane_write,
    input  dsi_pkg::lane_mask_t  lane_full
);
    import dsi_pkg::*;

    pkt_hdr_t  seq_hdr;   // sequencer to queue
    pkt_hdr_t  head_hdr;  // queue head to mux
    logic      hdr_write;
    logic      hdr_full;
    logic      hdr_empty;
    logic      hdr_read;
    mux_word_t mux_word;
    logic      word_full;
    logic      word_take;

    frame_sequencer seq_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .streaming_enable (streaming_enable),
        .timing_cfg       (timing_cfg),
        .hdr_write        (hdr_write),
        .hdr              (seq_hdr),
        .hdr_full         (hdr_full)
    );

    hdr_queue queue_i (
        .clk   (clk),
        .rst_n (rst_n),
        .write (hdr_write),
        .wdata (seq_hdr),
        .read  (hdr_read),
        .rdata (head_hdr),
        .full  (hdr_full),
        .empty (hdr_empty)
    );

    packet_mux mux_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hdr       (head_hdr),
        .hdr_empty (hdr_empty),
        .hdr_read  (hdr_read),
        .pix_data  (pix_data),
        .pix_empty (pix_empty),
        .pix_read  (pix_read),
        .word      (mux_word),
        .word_full (word_full),
        .word_take (word_take)
    );

    lane_distributor dist_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_count (lane_count),
        .word       (mux_word),
        .word_full  (word_full),
        .word_take  (word_take),
        .lane_data  (lane_data),
        .lane_write (lane_write),
        .lane_full  (lane_full)
    );

endmodule

//--- dsi_packet_assembler_assert.sv
`timescale 1ns/1ps

module dsi_packet_assembler_assert (
    input logic                clk,
    input logic                rst_n,
    input logic [2:0]          lane_count,
    input logic                pix_read,
    input logic                pix_empty,
    input dsi_pkg::lane_mask_t lane_write,
    input dsi_pkg::lane_mask_t lane_full
);
    import dsi_pkg::*;

    int         fail_count;  // read by the testbench
    lane_mask_t lanes_below;

    initial
        fail_count = 0;

    always_comb
    begin
        for (int i = 0; i < MAX_LANES; i++)
            lanes_below[i] = (i < lane_count);
    end

    a_lane_range: assert property (@(posedge clk) disable iff (!rst_n)
        (lane_write & ~lanes_below) == '0)
        else
        begin
            $error("lane_write %b enables a lane at or above lane_count %0d",
                   lane_write, lane_count);
            fail_count++;
        end

    // whole group stalls on any full lane
    a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (lane_full != '0) |-> (lane_write == '0))
        else
        begin
            $error("lane_write %b while lane_full is %b", lane_write, lane_full);
            fail_count++;
        end

    a_pix_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pix_empty |-> !pix_read)
        else
        begin
            $error("pix_read while the pixel FIFO is empty");
            fail_count++;
        end

endmodule

//--- dsi_pkg.sv
package dsi_pkg;

    // data identifiers, virtual channel 0
    localparam logic [7:0] PKT_VSS      = 8'h01;
    localparam logic [7:0] PKT_HSS      = 8'h21;
    localparam logic [7:0] PKT_BLANKING = 8'h19;
    localparam logic [7:0] PKT_PPS24    = 8'h3E;

    localparam logic [7:0] BLANK_BYTE = 8'h55; // blanking payload filler

    localparam int HDR_BYTES       = 4;
    localparam int CRC_BYTES       = 2;
    localparam int MAX_LANES       = 4;
    localparam int CNT_W           = 16;
    localparam int HDR_QUEUE_DEPTH = 4;

    typedef struct packed {
        logic [7:0]       data_id;
        logic [CNT_W-1:0] word_count;
    } pkt_hdr_t;

    typedef struct packed {
        logic [CNT_W-1:0] pixels_per_line;
        logic [CNT_W-1:0] hbp_bytes;        // blanking payload lengths in bytes
        logic [CNT_W-1:0] hfp_bytes;
        logic [CNT_W-1:0] line_blank_bytes;
        logic [CNT_W-1:0] vbp_lines;
        logic [CNT_W-1:0] active_lines;
        logic [CNT_W-1:0] vfp_lines;
    } timing_cfg_t;

    // byte 0 of data goes out first
    typedef struct packed {
        logic [31:0] data;
        logic [2:0]  byte_count; // 1 to 4
    } mux_word_t;

    typedef logic [MAX_LANES-1:0][7:0] lane_word_t;
    typedef logic [MAX_LANES-1:0]      lane_mask_t;

endpackage

//--- flist.f
dsi_pkg.sv
header_ecc.sv
payload_crc.sv
hdr_queue.sv
frame_sequencer.sv
packet_mux.sv
lane_distributor.sv
dsi_packet_assembler.sv
dsi_packet_assembler_assert.sv
tb_dsi_packet_assembler.sv

//--- frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 streaming_enable,
    input  dsi_pkg::timing_cfg_t timing_cfg,
    output logic                 hdr_write,
    output dsi_pkg::pkt_hdr_t    hdr,
    input  logic                 hdr_full
);
    import dsi_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_VSS,
        S_VSS_BLANK,
        S_VBP_HSS,
        S_VBP_BLANK,
        S_ACT_HSS,
        S_ACT_HBP,
        S_ACT_PIX,
        S_ACT_HFP,
        S_VFP_HSS,
        S_VFP_BLANK
    } seq_state_t;

    seq_state_t       state;
    logic [CNT_W-1:0] lines_left; // reloaded at the start of each phase
    logic             hdr_valid;
    logic             advance;

    always_comb
    begin
        hdr_valid      = 1'b1;
        hdr.data_id    = PKT_BLANKING;
        hdr.word_count = '0;
        case (state)
            S_VSS:
                hdr.data_id = PKT_VSS;
            S_VSS_BLANK, S_VBP_BLANK, S_VFP_BLANK:
                hdr.word_count = timing_cfg.line_blank_bytes;
            S_VBP_HSS, S_ACT_HSS, S_VFP_HSS:
            begin
                hdr.data_id = PKT_HSS;
                hdr_valid   = (lines_left != '0); // zero means phase is over
            end
            S_ACT_HBP:
                hdr.word_count = timing_cfg.hbp_bytes;
            S_ACT_PIX:
            begin
                hdr.data_id    = PKT_PPS24;
                hdr.word_count = (timing_cfg.pixels_per_line << 1) + timing_cfg.pixels_per_line;
            end
            S_ACT_HFP:
                hdr.word_count = timing_cfg.hfp_bytes;
            default:
                hdr_valid = 1'b0;
        endcase
    end

    assign advance   = hdr_valid && !hdr_full;
    assign hdr_write = advance;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= S_IDLE;
            lines_left <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (streaming_enable)
                        state <= S_VSS;
                S_VSS:
                    if (advance)
                        state <= S_VSS_BLANK;
                S_VSS_BLANK:
                    if (advance)
                    begin
                        state      <= S_VBP_HSS;
                        lines_left <= timing_cfg.vbp_lines;
                    end
                S_VBP_HSS:
                    if (lines_left == '0)
                    begin
                        state      <= S_ACT_HSS;
                        lines_left <= timing_cfg.active_lines;
                    end
                    else if (advance)
                        state <= S_VBP_BLANK;
                S_ACT_HSS:
                    if (lines_left == '0)
                    begin
                        state      <= S_VFP_HSS;
                        lines_left <= timing_cfg.vfp_lines;
                    end
                    else if (advance)
                        state <= S_ACT_HBP;
                S_ACT_HBP:
                    if (advance)
                        state <= S_ACT_PIX;
                S_ACT_PIX:
                    if (advance)
                        state <= S_ACT_HFP;
                S_VFP_HSS:
                    if (lines_left == '0)
                        state <= streaming_enable ? S_VSS : S_IDLE; // frame done
                    else if (advance)
                        state <= S_VFP_BLANK;
                S_VBP_BLANK, S_ACT_HFP, S_VFP_BLANK:
                    if (advance)
                    begin
                        lines_left <= lines_left - 1'b1; // line finished
                        if (state == S_VBP_BLANK)
                            state <= S_VBP_HSS;
                        else if (state == S_ACT_HFP)
                            state <= S_ACT_HSS;
                        else
                            state <= S_VFP_HSS;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- hdr_queue.sv
`timescale 1ns/1ps

module hdr_queue #(
    parameter int DEPTH = dsi_pkg::HDR_QUEUE_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              write,
    input  dsi_pkg::pkt_hdr_t wdata,
    input  logic              read,
    output dsi_pkg::pkt_hdr_t rdata,
    output logic              full,
    output logic              empty
);
    import dsi_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    pkt_hdr_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   used;   // entries held
    logic             do_write;
    logic             do_read;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1; // wraps for any depth
    endfunction

    assign do_write = write && !full;
    assign do_read  = read && !empty;
    assign full     = (used == (PTR_W+1)'(DEPTH));
    assign empty    = (used == '0);
    assign rdata    = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_read)
                rd_ptr <= ptr_inc(rd_ptr);
            used <= used + do_write - do_read;
        end
    end

endmodule

//--- header_ecc.sv
`timescale 1ns/1ps

module header_ecc (
    input  logic [23:0] hdr_bits,
    output logic [7:0]  ecc
);

    // hamming parity, each mask selects the header bits covered by one ecc bit
    always_comb
    begin
        ecc[0] = ^(hdr_bits & 24'hF1_2CB7);
        ecc[1] = ^(hdr_bits & 24'hF2_555B);
        ecc[2] = ^(hdr_bits & 24'h74_9A6D);
        ecc[3] = ^(hdr_bits & 24'hB8_E38E);
        ecc[4] = ^(hdr_bits & 24'hDF_03F0);
        ecc[5] = ^(hdr_bits & 24'hEF_FC00);
        ecc[6] = 1'b0; // reserved
        ecc[7] = 1'b0;
    end

endmodule

//--- lane_distributor.sv
`timescale 1ns/1ps

module lane_distributor (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [2:0]         lane_count,
    input  dsi_pkg::mux_word_t word,
    input  logic               word_full,
    output logic               word_take,
    output dsi_pkg::lane_word_t lane_data,
    output dsi_pkg::lane_mask_t lane_write,
    input  dsi_pkg::lane_mask_t lane_full
);
    import dsi_pkg::*;

    logic [63:0] sreg;     // byte 0 is the next one out
    logic [3:0]  count;    // valid bytes in sreg, 0 to 8
    logic [2:0]  lanes;
    logic [2:0]  out_n;
    logic        out_fire;
    logic [3:0]  shift_n;
    logic [3:0]  rem;      // bytes left after this cycle's group
    logic [63:0] in_bytes;

    assign lanes = (lane_count == 3'd0) ? 3'd1 :
                   (lane_count > 3'(MAX_LANES)) ? 3'(MAX_LANES) : lane_count;

    assign out_n    = (count >= {1'b0, lanes}) ? lanes : count[2:0];
    // full group, or a short flush once nothing else is waiting
    assign out_fire = (lane_full == '0) && (count != 4'd0) &&
                      ((count >= {1'b0, lanes}) || !word_full);
    assign shift_n   = out_fire ? {1'b0, out_n} : 4'd0;
    assign rem       = count - shift_n;
    assign word_take = word_full && (rem <= 4'd4);

    // unused bytes of a short word stay zero
    always_comb
    begin
        in_bytes = '0;
        for (int i = 0; i < 4; i++)
            if (i < word.byte_count)
                in_bytes[8*i +: 8] = word.data[8*i +: 8];
    end

    assign lane_data  = sreg[31:0];
    assign lane_write = out_fire ? lane_mask_t'((5'd1 << out_n) - 5'd1) : '0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sreg  <= '0;
            count <= '0;
        end
        else
        begin
            sreg  <= (sreg >> {shift_n, 3'b000}) |
                     (word_take ? (in_bytes << {rem, 3'b000}) : 64'd0);
            count <= rem + (word_take ? {1'b0, word.byte_count} : 4'd0);
        end
    end

endmodule

//--- packet_mux.sv
`timescale 1ns/1ps

module packet_mux (
    input  logic               clk,
    input  logic               rst_n,
    input  dsi_pkg::pkt_hdr_t  hdr,
    input  logic               hdr_empty,
    output logic               hdr_read,
    input  logic [31:0]        pix_data,
    input  logic               pix_empty,
    output logic               pix_read,
    output dsi_pkg::mux_word_t word,
    output logic               word_full,
    input  logic               word_take
);
    import dsi_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_HEADER,
        M_PIX,
        M_BLANK,
        M_CRC
    } mux_state_t;

    mux_state_t       state;
    pkt_hdr_t         cur_hdr;    // header being sent
    logic [CNT_W-1:0] bytes_left; // payload bytes still to load
    logic [2:0]       chunk;
    logic [7:0]       ecc;
    logic [15:0]      crc;
    logic             can_load;
    logic             load;
    logic             long_pkt;
    logic             crc_clear;
    logic             crc_update;
    mux_word_t        next_word;

    header_ecc ecc_i (
        .hdr_bits ({cur_hdr.word_count, cur_hdr.data_id}),
        .ecc      (ecc)
    );

    payload_crc crc_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (crc_clear),
        .update     (crc_update),
        .data       (next_word.data),
        .byte_count (next_word.byte_count),
        .crc        (crc)
    );

    assign long_pkt = (cur_hdr.data_id == PKT_PPS24) || (cur_hdr.data_id == PKT_BLANKING);
    assign can_load = !word_full || word_take; // register frees up this cycle
    assign chunk    = (|bytes_left[CNT_W-1:2]) ? 3'd4 : bytes_left[2:0];
    assign hdr_read = (state == M_IDLE) && !hdr_empty;
    assign pix_read = (state == M_PIX) && can_load && !pix_empty;

    always_comb
    begin
        load                 = 1'b0;
        next_word.data       = {16'h0000, crc};
        next_word.byte_count = 3'(CRC_BYTES);
        case (state)
            M_HEADER:
            begin
                load                 = can_load;
                next_word.data       = {ecc, cur_hdr.word_count, cur_hdr.data_id};
                next_word.byte_count = 3'(HDR_BYTES);
            end
            M_PIX:
            begin
                load                 = pix_read;
                next_word.data       = pix_data;
                next_word.byte_count = chunk;
            end
            M_BLANK:
            begin
                load                 = can_load;
                next_word.data       = {4{BLANK_BYTE}};
                next_word.byte_count = chunk;
            end
            M_CRC:
                load = can_load; // crc low byte first
            default:
                load = 1'b0;
        endcase
    end

    assign crc_clear  = load && (state == M_HEADER);
    assign crc_update = load && ((state == M_PIX) || (state == M_BLANK));

    always_ff @(posedge clk)
    begin
        if (hdr_read)
            cur_hdr <= hdr;
        if (load)
            word <= next_word;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= M_IDLE;
            bytes_left <= '0;
            word_full  <= 1'b0;
        end
        else
        begin
            word_full <= load || (word_full && !word_take);
            case (state)
                M_IDLE:
                    if (hdr_read)
                        state <= M_HEADER;
                M_HEADER:
                    if (load)
                    begin
                        bytes_left <= cur_hdr.word_count;
                        if (!long_pkt)
                            state <= M_IDLE; // short packet, no payload or crc
                        else if (cur_hdr.word_count == '0)
                            state <= M_CRC;
                        else if (cur_hdr.data_id == PKT_PPS24)
                            state <= M_PIX;
                        else
                            state <= M_BLANK;
                    end
                M_PIX, M_BLANK:
                    if (load)
                    begin
                        bytes_left <= bytes_left - CNT_W'(chunk);
                        if (bytes_left <= CNT_W'(4))
                            state <= M_CRC;
                    end
                M_CRC:
                    if (load)
                        state <= M_IDLE;
                default:
                    state <= M_IDLE;
            endcase
        end
    end

endmodule

//--- payload_crc.sv
`timescale 1ns/1ps

module payload_crc (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        update,
    input  logic [31:0] data,
    input  logic [2:0]  byte_count,
    output logic [15:0] crc
);

    logic [15:0] next_crc;

    // one byte, lsb first, x^16 + x^12 + x^5 + 1 reflected
    function automatic logic [15:0] crc_byte(input logic [15:0] seed, input logic [7:0] b);
        logic [15:0] c;
        c = seed;
        for (int k = 0; k < 8; k++)
            c = (c >> 1) ^ ((c[0] ^ b[k]) ? 16'h8408 : 16'h0000);
        return c;
    endfunction

    always_comb
    begin
        next_crc = crc;
        for (int i = 0; i < 4; i++)
            if (i < byte_count)
                next_crc = crc_byte(next_crc, data[8*i +: 8]);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= 16'hFFFF;
        else if (clear)
            crc <= 16'hFFFF; // seed for the next packet
        else if (update)
            crc <= next_crc;
    end

endmodule

//--- tb_dsi_packet_assembler.sv
`timescale 1ns/1ps

module tb_dsi_packet_assembler;
    import dsi_pkg::*;

    typedef logic [7:0] byte_q_t[$];

    logic        clk;
    logic        rst_n;
    logic        streaming_enable;
    logic [2:0]  lane_count;
    timing_cfg_t timing_cfg;
    logic [31:0] pix_data;
    logic        pix_empty;
    logic        pix_read;
    lane_word_t  lane_data;
    lane_mask_t  lane_write;
    lane_mask_t  lane_full;

    byte_q_t     exp_q;      // model stream for the current run
    byte_q_t     pix_bytes;  // pixel words split into stream order
    logic [31:0] pix_src[$]; // words still to hand to the DUT
    byte_q_t     none;
    int          pix_pos;
    int          got_n;      // bytes collected from the lanes
    int          frame_len;
    int          cycles;
    int          cycle_limit;

    dsi_packet_assembler dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .streaming_enable (streaming_enable),
        .lane_count       (lane_count),
        .timing_cfg       (timing_cfg),
        .pix_data         (pix_data),
        .pix_empty        (pix_empty),
        .pix_read         (pix_read),
        .lane_data        (lane_data),
        .lane_write       (lane_write),
        .lane_full        (lane_full)
    );

    bind dsi_packet_assembler dsi_packet_assembler_assert assert_i (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
        begin
            $display("Fail %s: expected %02h, got %02h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_group(input string name, input lane_mask_t exp, input lane_mask_t act);
        if (act !== exp)
        begin
            $display("Fail %s: expected mask %b, got %b", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // lanes 0 to n-1
    function automatic lane_mask_t low_lanes(input int n);
        lane_mask_t m;
        m = '0;
        for (int i = 0; i < MAX_LANES; i++)
            m[i] = (i < n);
        return m;
    endfunction

    // dsi hamming parity over the 24 header bits
    function automatic logic [7:0] ecc_of(input logic [23:0] d);
        logic [7:0] e;
        e    = 8'h00;
        e[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
        e[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
        e[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
        e[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
        e[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
        e[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
        return e;
    endfunction

    function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [7:0] b);
        logic [15:0] r;
        r = c ^ {8'h00, b};
        repeat (8)
            r = r[0] ? ((r >> 1) ^ 16'h8408) : (r >> 1);
        return r;
    endfunction

    function automatic byte_q_t blank_bytes(input int n);
        byte_q_t q;
        repeat (n)
            q.push_back(BLANK_BYTE);
        return q;
    endfunction

    task automatic add_packet(input logic [7:0] id, input byte_q_t payload);
        logic [15:0] crc;
        logic [15:0] wc;
        wc = 16'(payload.size());
        exp_q.push_back(id);
        exp_q.push_back(wc[7:0]);
        exp_q.push_back(wc[15:8]);
        exp_q.push_back(ecc_of({wc, id}));
        if (id == PKT_PPS24 || id == PKT_BLANKING)
        begin
            crc = 16'hFFFF;
            foreach (payload[i])
            begin
                exp_q.push_back(payload[i]);
                crc = crc_step(crc, payload[i]);
            end
            exp_q.push_back(crc[7:0]); // low byte first
            exp_q.push_back(crc[15:8]);
        end
    endtask

    task automatic add_frame(input timing_cfg_t cfg);
        byte_q_t pix;
        add_packet(PKT_VSS, none);
        add_packet(PKT_BLANKING, blank_bytes(cfg.line_blank_bytes));
        repeat (cfg.vbp_lines)
        begin
            add_packet(PKT_HSS, none);
            add_packet(PKT_BLANKING, blank_bytes(cfg.line_blank_bytes));
        end
        repeat (cfg.active_lines)
        begin
            pix.delete();
            repeat (3 * cfg.pixels_per_line)
            begin
                pix.push_back(pix_bytes[pix_pos]);
                pix_pos++;
            end
            add_packet(PKT_HSS, none);
            add_packet(PKT_BLANKING, blank_bytes(cfg.hbp_bytes));
            add_packet(PKT_PPS24, pix);
            add_packet(PKT_BLANKING, blank_bytes(cfg.hfp_bytes));
        end
        repeat (cfg.vfp_lines)
        begin
            add_packet(PKT_HSS, none);
            add_packet(PKT_BLANKING, blank_bytes(cfg.line_blank_bytes));
        end
    endtask

    // one cycle, new inputs on the falling edge
    task automatic step();
        @(negedge clk);
        lane_full = ($urandom_range(0, 3) == 0) ? '1 : '0;
        pix_empty = (pix_src.size() == 0) || ($urandom_range(0, 4) == 0);
        pix_data  = (pix_src.size() != 0) ? pix_src[0] : 32'h0;
    endtask

    task automatic collect_group();
        int n;
        n = $countones(lane_write);
        check_group($sformatf("lanes %0d group at byte %0d", lane_count, got_n),
                    (n >= lane_count) ? low_lanes(lane_count) : low_lanes(n), lane_write);
        for (int i = 0; i < MAX_LANES; i++)
            if (lane_write[i])
            begin
                if (got_n >= exp_q.size())
                begin
                    $display("Lanes wrote more bytes than the expected stream holds");
                    $display("Test failed");
                    $fatal(1);
                end
                else
                begin
                    check_byte($sformatf("lanes %0d byte %0d", lane_count, got_n),
                               exp_q[got_n], lane_data[i]);
                    got_n++;
                end
            end
    endtask

    task automatic run_case(input logic [2:0] lanes);
        timing_cfg_t cfg;
        logic [31:0] w;
        cfg.pixels_per_line  = 16'(4 * $urandom_range(1, 4));
        cfg.hbp_bytes        = 16'($urandom_range(1, 12));
        cfg.hfp_bytes        = 16'($urandom_range(1, 12));
        cfg.line_blank_bytes = 16'($urandom_range(1, 12));
        cfg.vbp_lines        = 16'($urandom_range(1, 2));
        cfg.active_lines     = 16'($urandom_range(2, 4));
        cfg.vfp_lines        = 16'($urandom_range(1, 2));
        pix_src.delete();
        pix_bytes.delete();
        exp_q.delete();
        repeat (2 * cfg.active_lines * cfg.pixels_per_line * 3 / 4) // two frames
        begin
            w = $urandom();
            pix_src.push_back(w);
            for (int b = 0; b < 4; b++)
                pix_bytes.push_back(w[8*b +: 8]);
        end
        pix_pos = 0;
        add_frame(cfg);
        frame_len = exp_q.size();
        add_frame(cfg);
        got_n            = 0;
        cycles           = 0;
        cycle_limit      = 20 * exp_q.size() + 1000;
        lane_count       = lanes;
        timing_cfg       = cfg;
        streaming_enable = 1'b1;
        while (got_n <= frame_len) // second frame is on the lanes
            step();
        streaming_enable = 1'b0;
        while (got_n < exp_q.size())
            step();
        repeat (200)
            step(); // any late write overruns the model
    endtask

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cycles++;
            if (pix_read && pix_src.size() != 0)
                void'(pix_src.pop_front());
            if (lane_write != '0)
                collect_group();
        end
    end

    always @(negedge clk)
    begin
        if (cycles > cycle_limit)
        begin
            $display("Timeout: stream still incomplete after %0d cycles", cycles);
            $display("Test failed");
            $fatal(1);
        end
        else if (dut_i.assert_i.fail_count != 0)
        begin
            $display("A port assertion on the DUT failed");
            $display("Test failed");
            $fatal(1);
        end
    end

    initial
    begin
        void'($urandom(32'h2d96_dc6d));
        rst_n            = 1'b0;
        streaming_enable = 1'b0;
        lane_count       = 3'd1;
        timing_cfg       = '0;
        pix_data         = '0;
        pix_empty        = 1'b1;
        lane_full        = '0;
        got_n            = 0;
        cycles           = 0;
        cycle_limit      = 1000;
        repeat (5)
            @(negedge clk);
        rst_n = 1'b1;
        for (int n = 1; n <= MAX_LANES; n++)
            run_case(3'(n));
        if (dut_i.assert_i.fail_count != 0)
        begin
            $display("A port assertion on the DUT failed");
            $display("Test failed");
            $fatal(1);
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
